/* hdl/controlPkg.sv */
package controlPkg;

	// primary opcode field in instr[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE  = 6'h00,
		OP_REGIMM = 6'h01,
		OP_J      = 6'h02,
		OP_JAL    = 6'h03,
		OP_BEQ    = 6'h04,
		OP_BNE    = 6'h05,
		OP_BLEZ   = 6'h06,
		OP_BGTZ   = 6'h07,
		OP_ADDIU  = 6'h09,
		OP_SLTI   = 6'h0a,
		OP_SLTIU  = 6'h0b,
		OP_ANDI   = 6'h0c,
		OP_ORI    = 6'h0d,
		OP_XORI   = 6'h0e,
		OP_LUI    = 6'h0f,
		OP_LB     = 6'h20,
		OP_LH     = 6'h21,
		OP_LW     = 6'h23,
		OP_LBU    = 6'h24,
		OP_LHU    = 6'h25,
		OP_SB     = 6'h28,
		OP_SH     = 6'h29,
		OP_SW     = 6'h2b
	} opcode_t;

	// R-type function field in instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_JR   = 6'h08,
		FN_JALR = 6'h09,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADDU = 4'd0,
		ALU_SUBU = 4'd1,
		ALU_SLT  = 4'd2,
		ALU_SLTU = 4'd3,
		ALU_AND  = 4'd4,
		ALU_OR   = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_NOR  = 4'd7,
		ALU_LUI  = 4'd8,
		ALU_SLL  = 4'd9,
		ALU_SRL  = 4'd10,
		ALU_SRA  = 4'd11,
		ALU_NONE = 4'd15
	} aluOp_t;

	// memory map by top address nibble
	localparam logic [3:0] DATA_REGION_VALUE  = 4'b0001;
	localparam logic [3:0] DATA_REGION_MASK   = 4'b1001;
	localparam logic [3:0] INSTR_REGION_VALUE = 4'b0010;
	localparam logic [3:0] INSTR_REGION_MASK  = 4'b1010;
	localparam logic [3:0] UART_REGION        = 4'b1000;

	localparam logic [31:0] UART_TX_READY = 32'h8000_0000;
	localparam logic [31:0] UART_RX_VALID = 32'h8000_0004;
	localparam logic [31:0] UART_TX_DATA  = 32'h8000_0008;
	localparam logic [31:0] UART_RX_DATA  = 32'h8000_000c;

	typedef struct packed {
		opcode_t    opcode;
		funct_t     funct;
		logic [4:0] rs;
		logic [4:0] rt;
	} fetchCtrl_t;

	typedef struct packed {
		opcode_t     opcode;
		funct_t      funct;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [31:0] rd1;
		logic [31:0] rd2;
		logic [31:0] aluOut;
		logic [1:0]  byteOffset;
	} exeCtrl_t;

	typedef struct packed {
		logic [31:0] aluOut;
		logic [4:0]  wa;
		logic        regWrite;
	} memCtrl_t;

	typedef struct packed {
		logic memToReg;
		logic regWrite;
		logic extType;
		logic aluSrc;
		logic regDst;
		logic jump;
		logic jr;
		logic jal;
	} decodeCtrl_t;

	typedef struct packed {
		logic aFromMtoE;
		logic bFromMtoE;
		logic aFromMtoF;
		logic bFromMtoF;
	} fwdSel_t;

endpackage

/* hdl/mainDecoder.sv */
`timescale 1ns/1ps

module mainDecoder (
	input  controlPkg::opcode_t     opcode,
	input  controlPkg::funct_t      funct,
	input  logic [31:0]             memAddr,
	output controlPkg::decodeCtrl_t ctrl
);
	import controlPkg::*;

	logic [3:0] memRegion;
	logic       legalRead;

	assign memRegion = memAddr[31:28];
	// loads may only hit data memory or the UART
	assign legalRead = ((memRegion & DATA_REGION_MASK) == DATA_REGION_VALUE) ||
		(memRegion == UART_REGION);

	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = (funct != FN_JR);
				ctrl.jr = (funct == FN_JR) || (funct == FN_JALR);
				ctrl.jal = (funct == FN_JALR);
			end
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
				// illegal read address blocks the writeback
				ctrl.regWrite = legalRead;
			end
			OP_SB, OP_SH, OP_SW: begin
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				// logical immediates are zero extended
				ctrl.extType = 1'b1;
			end
			OP_LUI: begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OP_J: begin
				ctrl.jump = 1'b1;
			end
			OP_JAL: begin
				ctrl.jump = 1'b1;
				ctrl.jal = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
			end
			default: begin
				// branches and unknown opcodes
				ctrl = '0;
			end
		endcase
	end

endmodule

/* hdl/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder (
	input  controlPkg::opcode_t opcode,
	input  controlPkg::funct_t  funct,
	output controlPkg::aluOp_t  aluOp
);
	import controlPkg::*;

	always_comb begin
		aluOp = ALU_NONE;
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_SLL:  aluOp = ALU_SLL;
					FN_SRL:  aluOp = ALU_SRL;
					FN_SRA:  aluOp = ALU_SRA;
					FN_ADDU: aluOp = ALU_ADDU;
					FN_SUBU: aluOp = ALU_SUBU;
					FN_AND:  aluOp = ALU_AND;
					FN_OR:   aluOp = ALU_OR;
					FN_XOR:  aluOp = ALU_XOR;
					FN_NOR:  aluOp = ALU_NOR;
					FN_SLT:  aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					// jr and jalr need no ALU
					default: aluOp = ALU_NONE;
				endcase
			end
			// address generation
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: aluOp = ALU_ADDU;
			OP_SB, OP_SH, OP_SW: aluOp = ALU_ADDU;
			OP_ADDIU: aluOp = ALU_ADDU;
			OP_SLTI:  aluOp = ALU_SLT;
			OP_SLTIU: aluOp = ALU_SLTU;
			OP_ANDI:  aluOp = ALU_AND;
			OP_ORI:   aluOp = ALU_OR;
			OP_XORI:  aluOp = ALU_XOR;
			OP_LUI:   aluOp = ALU_LUI;
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM: aluOp = ALU_SUBU;
			default: aluOp = ALU_NONE;
		endcase
	end

endmodule

/* hdl/writeEnableCtrl.sv */
`timescale 1ns/1ps

module writeEnableCtrl #(
	parameter logic [3:0] regionValue = controlPkg::DATA_REGION_VALUE,
	parameter logic [3:0] regionMask  = controlPkg::DATA_REGION_MASK
) (
	input  controlPkg::opcode_t opcode,
	input  logic [1:0]          byteOffset,
	input  logic [31:0]         addr,
	output logic [3:0]          writeEn
);
	import controlPkg::*;

	logic inRegion;

	// the mask clears the don't-care bits of the nibble
	assign inRegion = ((addr[31:28] & regionMask) == regionValue);

	always_comb begin
		writeEn = 4'b0000;
		if (inRegion) begin
			case (opcode)
				OP_SB: writeEn = 4'b0001 << byteOffset;
				OP_SH: writeEn = byteOffset[1] ? 4'b1100 : 4'b0011;
				OP_SW: writeEn = 4'b1111;
				default: writeEn = 4'b0000;
			endcase
		end
	end

endmodule

/* hdl/branchCtrl.sv */
`timescale 1ns/1ps

module branchCtrl (
	input  controlPkg::opcode_t opcode,
	input  logic [4:0]          rt,
	input  logic [31:0]         rd1,
	input  logic [31:0]         rd2,
	output logic                taken
);
	import controlPkg::*;

	logic isZero;
	logic isNeg;

	assign isZero = (rd1 == 32'd0);
	assign isNeg = rd1[31];

	always_comb begin
		case (opcode)
			OP_BEQ:  taken = (rd1 == rd2);
			OP_BNE:  taken = (rd1 != rd2);
			OP_BLEZ: taken = isNeg || isZero;
			OP_BGTZ: taken = !isNeg && !isZero;
			// rt[0] picks bgez over bltz
			OP_REGIMM: taken = rt[0] ? !isNeg : isNeg;
			default: taken = 1'b0;
		endcase
	end

endmodule

/* hdl/hazardCtrl.sv */
`timescale 1ns/1ps

module hazardCtrl (
	input  logic [4:0]          rsF,
	input  logic [4:0]          rtF,
	input  logic [4:0]          rsE,
	input  logic [4:0]          rtE,
	input  logic [4:0]          waM,
	input  logic                regWriteM,
	output controlPkg::fwdSel_t fwd
);

	logic mWrites;

	// $zero is never a forwarding source
	assign mWrites = regWriteM && (waM != 5'd0);

	assign fwd.aFromMtoE = mWrites && (waM == rsE);
	assign fwd.bFromMtoE = mWrites && (waM == rtE);
	assign fwd.aFromMtoF = mWrites && (waM == rsF);
	assign fwd.bFromMtoF = mWrites && (waM == rtF);

endmodule

/* hdl/uartCtrl.sv */
`timescale 1ns/1ps

module uartCtrl (
	input  controlPkg::opcode_t opcode,
	input  logic [31:0]         addr,
	input  logic                dataInReady,
	input  logic                dataOutValid,
	input  logic [7:0]          uartRxData,
	output logic                uartSel,
	output logic                dataInValid,
	output logic                dataOutReady,
	output logic [31:0]         uartReadData
);
	import controlPkg::*;

	logic isLoad;
	logic isStore;

	assign isLoad = (opcode == OP_LB) || (opcode == OP_LH) || (opcode == OP_LW) ||
		(opcode == OP_LBU) || (opcode == OP_LHU);
	// only byte and word stores reach the tx register
	assign isStore = (opcode == OP_SB) || (opcode == OP_SW);

	assign uartSel = isLoad && (addr[31:28] == UART_REGION);
	assign dataInValid = isStore && (addr == UART_TX_DATA);
	// pop the rx byte as it is read
	assign dataOutReady = isLoad && (addr == UART_RX_DATA);

	always_comb begin
		uartReadData = 32'd0;
		if (isLoad) begin
			case (addr)
				UART_TX_READY: uartReadData = {31'd0, dataInReady};
				UART_RX_VALID: uartReadData = {31'd0, dataOutValid};
				UART_RX_DATA:  uartReadData = {24'd0, uartRxData};
				default:       uartReadData = 32'd0;
			endcase
		end
	end

endmodule

/* hdl/control.sv */
`timescale 1ns/1ps

module control #(
	parameter logic [3:0] dataRegionValue  = controlPkg::DATA_REGION_VALUE,
	parameter logic [3:0] dataRegionMask   = controlPkg::DATA_REGION_MASK,
	parameter logic [3:0] instrRegionValue = controlPkg::INSTR_REGION_VALUE,
	parameter logic [3:0] instrRegionMask  = controlPkg::INSTR_REGION_MASK
) (
	input  controlPkg::fetchCtrl_t  fetch,
	input  controlPkg::exeCtrl_t    exe,
	input  controlPkg::memCtrl_t    mem,
	input  logic                    dataInReady,
	input  logic                    dataOutValid,
	input  logic [7:0]              uartRxData,
	output controlPkg::decodeCtrl_t ctrl,
	output controlPkg::aluOp_t      aluOp,
	output logic [3:0]              dataMemWriteEn,
	output logic [3:0]              instrMemWriteEn,
	output logic                    branchTaken,
	output controlPkg::fwdSel_t     fwd,
	output logic                    uartSel,
	output logic                    dataInValid,
	output logic                    dataOutReady,
	output logic [31:0]             uartReadData
);

	// F stage decode checks loads against the M stage address
	mainDecoder mainDecoder0 (
		.opcode(fetch.opcode),
		.funct(fetch.funct),
		.memAddr(mem.aluOut),
		.ctrl(ctrl)
	);

	aluDecoder aluDecoder0 (
		.opcode(exe.opcode),
		.funct(exe.funct),
		.aluOp(aluOp)
	);

	writeEnableCtrl #(
		.regionValue(dataRegionValue),
		.regionMask(dataRegionMask)
	) dataWriteEn0 (
		.opcode(exe.opcode),
		.byteOffset(exe.byteOffset),
		.addr(exe.aluOut),
		.writeEn(dataMemWriteEn)
	);

	// instruction memory is writable for self-loading code
	writeEnableCtrl #(
		.regionValue(instrRegionValue),
		.regionMask(instrRegionMask)
	) instrWriteEn0 (
		.opcode(exe.opcode),
		.byteOffset(exe.byteOffset),
		.addr(exe.aluOut),
		.writeEn(instrMemWriteEn)
	);

	branchCtrl branchCtrl0 (
		.opcode(exe.opcode),
		.rt(exe.rt),
		.rd1(exe.rd1),
		.rd2(exe.rd2),
		.taken(branchTaken)
	);

	hazardCtrl hazardCtrl0 (
		.rsF(fetch.rs),
		.rtF(fetch.rt),
		.rsE(exe.rs),
		.rtE(exe.rt),
		.waM(mem.wa),
		.regWriteM(mem.regWrite),
		.fwd(fwd)
	);

	uartCtrl uartCtrl0 (
		.opcode(exe.opcode),
		.addr(exe.aluOut),
		.dataInReady(dataInReady),
		.dataOutValid(dataOutValid),
		.uartRxData(uartRxData),
		.uartSel(uartSel),
		.dataInValid(dataInValid),
		.dataOutReady(dataOutReady),
		.uartReadData(uartReadData)
	);

endmodule

/* bench/controlRef.svh */
typedef struct packed {
	logic        sel;
	logic        inValid;
	logic        outReady;
	logic [31:0] readData;
} uartExp_t;

// 13/17/5 xorshift
function automatic logic [31:0] xorshift(logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic isLoadOp(logic [5:0] op);
	return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
endfunction

function automatic decodeCtrl_t refDecode(logic [5:0] op, logic [5:0] fn, logic [31:0] addr);
	decodeCtrl_t c;
	logic legalRead;
	c = '0;
	// data nibbles 0zz1, or the UART nibble
	legalRead = (!addr[31] && addr[28]) || (addr[31:28] == 4'h8);
	if (op == OP_RTYPE) begin
		c.regDst = 1'b1;
		c.regWrite = (fn != FN_JR);
		c.jr = (fn == FN_JR) || (fn == FN_JALR);
		c.jal = (fn == FN_JALR);
	end else if (isLoadOp(op)) begin
		c.memToReg = 1'b1;
		c.aluSrc = 1'b1;
		c.regWrite = legalRead;
	end else if (op inside {OP_SB, OP_SH, OP_SW}) begin
		c.memToReg = 1'b1;
		c.aluSrc = 1'b1;
	end else if (op inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI}) begin
		c.aluSrc = 1'b1;
		c.regWrite = 1'b1;
	end else if (op inside {OP_ANDI, OP_ORI, OP_XORI}) begin
		c.aluSrc = 1'b1;
		c.regWrite = 1'b1;
		c.extType = 1'b1;
	end else if (op == OP_J) begin
		c.jump = 1'b1;
	end else if (op == OP_JAL) begin
		c.jump = 1'b1;
		c.jal = 1'b1;
		c.regWrite = 1'b1;
		c.regDst = 1'b1;
	end
	return c;
endfunction

function automatic aluOp_t refAluOp(logic [5:0] op, logic [5:0] fn);
	aluOp_t a;
	a = ALU_NONE;
	if (op == OP_RTYPE) begin
		case (fn)
			FN_SLL:  a = ALU_SLL;
			FN_SRL:  a = ALU_SRL;
			FN_SRA:  a = ALU_SRA;
			FN_ADDU: a = ALU_ADDU;
			FN_SUBU: a = ALU_SUBU;
			FN_AND:  a = ALU_AND;
			FN_OR:   a = ALU_OR;
			FN_XOR:  a = ALU_XOR;
			FN_NOR:  a = ALU_NOR;
			FN_SLT:  a = ALU_SLT;
			FN_SLTU: a = ALU_SLTU;
			default: a = ALU_NONE;
		endcase
	end else if (isLoadOp(op) || (op inside {OP_SB, OP_SH, OP_SW, OP_ADDIU})) begin
		a = ALU_ADDU;
	end else if (op == OP_SLTI) begin
		a = ALU_SLT;
	end else if (op == OP_SLTIU) begin
		a = ALU_SLTU;
	end else if (op == OP_ANDI) begin
		a = ALU_AND;
	end else if (op == OP_ORI) begin
		a = ALU_OR;
	end else if (op == OP_XORI) begin
		a = ALU_XOR;
	end else if (op == OP_LUI) begin
		a = ALU_LUI;
	end else if (op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM}) begin
		a = ALU_SUBU;
	end
	return a;
endfunction

function automatic logic [3:0] refWriteEn(logic [5:0] op, logic [1:0] off, logic [31:0] addr,
	logic instrRegion);
	logic       inRegion;
	logic [3:0] we;
	// data memory is 0zz1, instruction memory 0z1z
	inRegion = !addr[31] && (instrRegion ? addr[29] : addr[28]);
	we = 4'b0000;
	if (inRegion && op == OP_SB) begin
		we[off] = 1'b1;
	end else if (inRegion && op == OP_SH) begin
		we = off[1] ? 4'b1100 : 4'b0011;
	end else if (inRegion && op == OP_SW) begin
		we = 4'b1111;
	end
	return we;
endfunction

function automatic logic refBranch(logic [5:0] op, logic [4:0] rt, logic [31:0] a,
	logic [31:0] b);
	logic signed [31:0] sa;
	logic               t;
	sa = a;
	t = 1'b0;
	if (op == OP_BEQ) t = (a == b);
	else if (op == OP_BNE) t = (a != b);
	else if (op == OP_BLEZ) t = (sa <= 0);
	else if (op == OP_BGTZ) t = (sa > 0);
	// bgez when rt[0] is set, bltz otherwise
	else if (op == OP_REGIMM) t = rt[0] ? (sa >= 0) : (sa < 0);
	return t;
endfunction

function automatic fwdSel_t refFwd(logic [4:0] rsF, logic [4:0] rtF, logic [4:0] rsE,
	logic [4:0] rtE, logic [4:0] wa, logic we);
	fwdSel_t f;
	f.aFromMtoE = we && wa != 5'd0 && wa == rsE;
	f.bFromMtoE = we && wa != 5'd0 && wa == rtE;
	f.aFromMtoF = we && wa != 5'd0 && wa == rsF;
	f.bFromMtoF = we && wa != 5'd0 && wa == rtF;
	return f;
endfunction

function automatic uartExp_t refUart(logic [5:0] op, logic [31:0] addr, logic inReady,
	logic outValid, logic [7:0] rxData);
	uartExp_t u;
	u = '0;
	if (isLoadOp(op) && addr[31:28] == 4'h8) begin
		u.sel = 1'b1;
		if (addr == 32'h8000_0000) begin
			u.readData = {31'd0, inReady};
		end else if (addr == 32'h8000_0004) begin
			u.readData = {31'd0, outValid};
		end else if (addr == 32'h8000_000c) begin
			u.readData = {24'd0, rxData};
			u.outReady = 1'b1;
		end
	end
	// tx accepts byte and word stores only
	if ((op == OP_SB || op == OP_SW) && addr == 32'h8000_0008) begin
		u.inValid = 1'b1;
	end
	return u;
endfunction

/* bench/controlTb.sv */
`timescale 1ns/1ps

module controlTb;
	import controlPkg::*;

	localparam int NUM_VECTORS = 2000;
	localparam int RESET_CYCLES = 5;
	// reset, one cycle per vector, and slack
	localparam int CYCLE_LIMIT = RESET_CYCLES + NUM_VECTORS + 95;

	// last nine entries are not legal opcodes
	localparam logic [5:0] OPCODES [32] = '{
		OP_RTYPE, OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB,
		OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW, 6'h08,
		6'h10, 6'h11, 6'h1f, 6'h22, 6'h26, 6'h2a, 6'h30, 6'h3f
	};
	localparam logic [5:0] FUNCTS [16] = '{
		FN_SLL, FN_SRL, FN_SRA, FN_JR, FN_JALR, FN_ADDU, FN_SUBU, FN_AND,
		FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU, 6'h01, 6'h20, 6'h3f
	};

	logic        clk;
	logic        rst;
	fetchCtrl_t  fetch;
	exeCtrl_t    exe;
	memCtrl_t    mem;
	logic        dataInReady;
	logic        dataOutValid;
	logic [7:0]  uartRxData;
	decodeCtrl_t ctrl;
	aluOp_t      aluOp;
	logic [3:0]  dataMemWriteEn;
	logic [3:0]  instrMemWriteEn;
	logic        branchTaken;
	fwdSel_t     fwd;
	logic        uartSel;
	logic        dataInValid;
	logic        dataOutReady;
	logic [31:0] uartReadData;

	logic [31:0] rngState;
	logic        vectorLive;
	int          cycles = 0;
	int          checks = 0;
	int          ctrlErrors = 0;
	int          aluErrors = 0;
	int          wenErrors = 0;
	int          branchErrors = 0;
	int          fwdErrors = 0;
	int          uartErrors = 0;

	`include "controlRef.svh"

	control dut0 (
		.fetch(fetch),
		.exe(exe),
		.mem(mem),
		.dataInReady(dataInReady),
		.dataOutValid(dataOutValid),
		.uartRxData(uartRxData),
		.ctrl(ctrl),
		.aluOp(aluOp),
		.dataMemWriteEn(dataMemWriteEn),
		.instrMemWriteEn(instrMemWriteEn),
		.branchTaken(branchTaken),
		.fwd(fwd),
		.uartSel(uartSel),
		.dataInValid(dataInValid),
		.dataOutReady(dataOutReady),
		.uartReadData(uartReadData)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// small register numbers half the time so matches occur
	function automatic logic [4:0] pickReg(logic [7:0] r);
		return r[7] ? r[4:0] : {3'd0, r[1:0]};
	endfunction

	function automatic logic [31:0] pickOperand(logic [31:0] r);
		logic [31:0] v;
		case (r[1:0])
			2'd0: v = 32'd0;
			2'd1: v = r | 32'h8000_0000;
			2'd2: v = r & 32'h7fff_ffff;
			default: v = 32'hffff_ffff;
		endcase
		return v;
	endfunction

	function automatic logic [31:0] pickAddr(logic [31:0] sel, logic [31:0] low);
		logic [31:0] a;
		case (sel[2:0])
			// the four UART registers
			3'd0, 3'd1: a = {28'h800_0000, sel[4:3], 2'b00};
			3'd2: a = {4'h8, low[27:0]};
			3'd3: a = {1'b0, sel[4:3], 1'b1, low[27:0]};
			3'd4: a = {1'b0, sel[4], 1'b1, sel[3], low[27:0]};
			3'd5: a = {sel[7:4], low[27:0]};
			default: a = low;
		endcase
		return a;
	endfunction

	function automatic int totalErrors();
		return ctrlErrors + aluErrors + wenErrors + branchErrors + fwdErrors + uartErrors;
	endfunction

	task automatic driveVector();
		fetchCtrl_t  f;
		exeCtrl_t    e;
		memCtrl_t    m;
		logic [31:0] r;
		r = nextRand();
		f.opcode = opcode_t'(OPCODES[r[4:0]]);
		f.funct = funct_t'(FUNCTS[r[11:8]]);
		f.rs = pickReg(r[23:16]);
		f.rt = pickReg(r[31:24]);
		r = nextRand();
		e.opcode = opcode_t'(OPCODES[r[4:0]]);
		e.funct = funct_t'(FUNCTS[r[11:8]]);
		e.rs = pickReg(r[23:16]);
		e.rt = pickReg(r[31:24]);
		e.byteOffset = r[6:5];
		e.rd1 = pickOperand(nextRand());
		// equal operands a quarter of the time
		r = nextRand();
		e.rd2 = (r[31:30] == 2'd0) ? e.rd1 : pickOperand(r);
		e.aluOut = pickAddr(nextRand(), nextRand());
		m.aluOut = pickAddr(nextRand(), nextRand());
		r = nextRand();
		m.wa = pickReg(r[7:0]);
		m.regWrite = r[8];
		fetch <= f;
		exe <= e;
		mem <= m;
		dataInReady <= r[9];
		dataOutValid <= r[10];
		uartRxData <= r[23:16];
		vectorLive <= 1'b1;
	endtask

	task automatic checkOutputs();
		decodeCtrl_t expCtrl;
		aluOp_t      expAlu;
		logic [3:0]  expData;
		logic [3:0]  expInstr;
		logic        expTaken;
		fwdSel_t     expFwd;
		uartExp_t    expUart;
		expCtrl = refDecode(fetch.opcode, fetch.funct, mem.aluOut);
		expAlu = refAluOp(exe.opcode, exe.funct);
		expData = refWriteEn(exe.opcode, exe.byteOffset, exe.aluOut, 1'b0);
		expInstr = refWriteEn(exe.opcode, exe.byteOffset, exe.aluOut, 1'b1);
		expTaken = refBranch(exe.opcode, exe.rt, exe.rd1, exe.rd2);
		expFwd = refFwd(fetch.rs, fetch.rt, exe.rs, exe.rt, mem.wa, mem.regWrite);
		expUart = refUart(exe.opcode, exe.aluOut, dataInReady, dataOutValid, uartRxData);
		checks++;
		assert (ctrl == expCtrl) else begin
			$display("[FAIL] ctrl: expected %h, got %h", expCtrl, ctrl);
			ctrlErrors++;
		end
		assert (aluOp == expAlu) else begin
			$display("[FAIL] aluOp: expected %h, got %h", expAlu, aluOp);
			aluErrors++;
		end
		assert (dataMemWriteEn == expData) else begin
			$display("[FAIL] dataMemWriteEn: expected %h, got %h", expData, dataMemWriteEn);
			wenErrors++;
		end
		assert (instrMemWriteEn == expInstr) else begin
			$display("[FAIL] instrMemWriteEn: expected %h, got %h", expInstr, instrMemWriteEn);
			wenErrors++;
		end
		assert (branchTaken == expTaken) else begin
			$display("[FAIL] branchTaken: expected %h, got %h", expTaken, branchTaken);
			branchErrors++;
		end
		assert (fwd == expFwd) else begin
			$display("[FAIL] fwd: expected %h, got %h", expFwd, fwd);
			fwdErrors++;
		end
		assert (uartSel == expUart.sel) else begin
			$display("[FAIL] uartSel: expected %h, got %h", expUart.sel, uartSel);
			uartErrors++;
		end
		assert (dataInValid == expUart.inValid) else begin
			$display("[FAIL] dataInValid: expected %h, got %h", expUart.inValid,
				dataInValid);
			uartErrors++;
		end
		assert (dataOutReady == expUart.outReady) else begin
			$display("[FAIL] dataOutReady: expected %h, got %h", expUart.outReady,
				dataOutReady);
			uartErrors++;
		end
		assert (uartReadData == expUart.readData) else begin
			$display("[FAIL] uartReadData: expected %h, got %h", expUart.readData,
				uartReadData);
			uartErrors++;
		end
	endtask

	initial begin
		rngState = 32'd31684;
		rst = 1'b1;
		vectorLive = 1'b0;
		fetch = '0;
		exe = '0;
		mem = '0;
		dataInReady = 1'b0;
		dataOutValid = 1'b0;
		uartRxData = 8'h00;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < NUM_VECTORS; i++) begin
			@(posedge clk);
			driveVector();
		end
		// last vector was compared on the falling edge before this
		@(posedge clk);
		$display("checks %0d, errors: ctrl %0d alu %0d wen %0d branch %0d fwd %0d uart %0d",
			checks, ctrlErrors, aluErrors, wenErrors, branchErrors, fwdErrors, uartErrors);
		if (totalErrors() == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// combinational outputs have settled by mid-cycle
	always @(negedge clk) begin
		if (!rst && vectorLive) begin
			checkOutputs();
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

endmodule

/* verilog.f */
+incdir+bench
hdl/controlPkg.sv
hdl/mainDecoder.sv
hdl/aluDecoder.sv
hdl/writeEnableCtrl.sv
hdl/branchCtrl.sv
hdl/hazardCtrl.sv
hdl/uartCtrl.sv
hdl/control.sv
bench/controlTb.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -f verilog.f --top-module controlTb -o controlSim &&
	./obj_dir/controlSim | tee /dev/stderr | grep "All tests passed" > /dev/null ||
	{ echo "simulation reported failure" >&2; exit 1; }
